// ==== batch_norm_defs.svh ====
`ifndef BATCH_NORM_DEFS_SVH
`define BATCH_NORM_DEFS_SVH

// Number of elements carried by every beat
`define BN_LANES 4

// Data, mean, weight and bias share one input format
`define BN_IN_W 8
`define BN_IN_F 3

// Difference of data and mean
// One extra integer bit keeps the subtraction exact
`define BN_SUB_W 9
`define BN_SUB_F 3

// Full precision product of the difference and the weight
`define BN_MUL_W 17
`define BN_MUL_F 6

// Sum of the product and the aligned bias
`define BN_ADD_W 18
`define BN_ADD_F 6

// Result format on data_out
`define BN_OUT_W 8
`define BN_OUT_F 3

`endif

// ==== batch_norm_pkg.sv ====
`default_nettype none

`include "batch_norm_defs.svh"

package batch_norm_pkg;

    // Every lane holds a two's complement value and is read back with $signed

    // Beat on the data, mean, weight and bias streams
    typedef struct packed {
        logic [`BN_LANES-1:0][`BN_IN_W-1:0] lane;
    } in_beat_t;

    // Register of the subtract stage
    typedef struct packed {
        logic [`BN_LANES-1:0][`BN_SUB_W-1:0] lane;
    } sub_beat_t;

    // Register of the multiply stage
    typedef struct packed {
        logic [`BN_LANES-1:0][`BN_MUL_W-1:0] lane;
    } mul_beat_t;

    // Register of the add stage, also used for the aligned bias
    typedef struct packed {
        logic [`BN_LANES-1:0][`BN_ADD_W-1:0] lane;
    } add_beat_t;

    // Beat leaving the block
    typedef struct packed {
        logic [`BN_LANES-1:0][`BN_OUT_W-1:0] lane;
    } out_beat_t;

    // Occupancy of a single pipeline register
    typedef enum logic {
        EMPTY = 1'b0,
        FULL  = 1'b1
    } stage_state_e;

endpackage

`default_nettype wire

// ==== fixed_cast.sv ====
`default_nettype none

module fixed_cast #(
    parameter int LANES = 4,
    parameter int IN_W  = 8,
    parameter int IN_F  = 3,
    parameter int OUT_W = 8,
    parameter int OUT_F = 3
) (
    input  logic [LANES*IN_W-1:0]  data_in,
    output logic [LANES*OUT_W-1:0] data_out
);

    // Only one of the two shifts is ever non-zero
    localparam int LSH = (OUT_F > IN_F) ? OUT_F - IN_F : 0;
    localparam int RSH = (IN_F > OUT_F) ? IN_F - OUT_F : 0;

    // Wide enough for the shifted input and for both output limits
    localparam int EXT_W = IN_W + LSH + OUT_W;

    localparam logic signed [EXT_W-1:0] MAX_V =
        {{(EXT_W - OUT_W + 1){1'b0}}, {(OUT_W - 1){1'b1}}};
    localparam logic signed [EXT_W-1:0] MIN_V =
        {{(EXT_W - OUT_W + 1){1'b1}}, {(OUT_W - 1){1'b0}}};

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [EXT_W-1:0] ext;
        logic signed [EXT_W-1:0] aligned;

        // Sign extension happens on the assignment to the wider signed net
        assign ext = $signed(data_in[i*IN_W +: IN_W]);

        // The arithmetic right shift drops fraction bits and rounds toward minus infinity
        assign aligned = (ext <<< LSH) >>> RSH;

        assign data_out[i*OUT_W +: OUT_W] =
            (aligned > MAX_V) ? MAX_V[OUT_W-1:0] :
            (aligned < MIN_V) ? MIN_V[OUT_W-1:0] :
                                aligned[OUT_W-1:0];
    end

endmodule

`default_nettype wire

// ==== skid_buffer.sv ====
`default_nettype none

module skid_buffer #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] data_in,
    input  logic             data_in_valid,
    output logic             data_in_ready,
    output logic [WIDTH-1:0] data_out,
    output logic             data_out_valid,
    input  logic             data_out_ready
);

    import batch_norm_pkg::*;

    stage_state_e     main_state;
    stage_state_e     spare_state;
    logic [WIDTH-1:0] main_data;
    logic [WIDTH-1:0] spare_data;

    logic in_fire;
    logic out_fire;
    logic load_main_from_in;
    logic load_main_from_spare;
    logic load_spare;

    // Ready comes straight from a flop, so the upstream sees no path from data_out_ready
    assign data_in_ready  = (spare_state == EMPTY);
    assign data_out_valid = (main_state == FULL);
    assign data_out       = main_data;

    assign in_fire  = data_in_valid && data_in_ready;
    assign out_fire = data_out_valid && data_out_ready;

    // The spare is only ever full while the main register is full
    assign load_main_from_in    = in_fire && ((main_state == EMPTY) || out_fire);
    assign load_main_from_spare = out_fire && (spare_state == FULL);
    assign load_spare           = in_fire && (main_state == FULL) && !out_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_state  <= EMPTY;
            spare_state <= EMPTY;
        end else begin
            if (load_main_from_in || load_main_from_spare) begin
                main_state <= FULL;
            end else if (out_fire) begin
                main_state <= EMPTY;
            end

            if (load_spare) begin
                spare_state <= FULL;
            end else if (load_main_from_spare) begin
                spare_state <= EMPTY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_main_from_spare) begin
            main_data <= spare_data;
        end else if (load_main_from_in) begin
            main_data <= data_in;
        end

        if (load_spare) begin
            spare_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== fixed_batch_norm1d.sv ====
`default_nettype none

`include "batch_norm_defs.svh"

module fixed_batch_norm1d (
    input  logic                     clk,
    input  logic                     rst,
    input  batch_norm_pkg::in_beat_t  data_in,
    input  logic                     data_in_valid,
    output logic                     data_in_ready,
    input  batch_norm_pkg::in_beat_t  mean,
    input  logic                     mean_valid,
    output logic                     mean_ready,
    input  batch_norm_pkg::in_beat_t  weight,
    input  logic                     weight_valid,
    output logic                     weight_ready,
    input  batch_norm_pkg::in_beat_t  bias,
    input  logic                     bias_valid,
    output logic                     bias_ready,
    output batch_norm_pkg::out_beat_t data_out,
    output logic                     data_out_valid,
    input  logic                     data_out_ready
);

    import batch_norm_pkg::*;

    // Operands aligned to the formats of the stages that use them
    sub_beat_t data_sub;
    sub_beat_t mean_sub;
    add_beat_t bias_add;
    out_beat_t sum_out;

    // Stage registers and their occupancy
    sub_beat_t    sub_reg;
    mul_beat_t    mul_reg;
    add_beat_t    add_reg;
    stage_state_e sub_state;
    stage_state_e mul_state;
    stage_state_e add_state;

    logic sub_accept;
    logic mul_accept;
    logic add_accept;
    logic sub_load;
    logic mul_load;
    logic add_load;
    logic skid_ready;

    fixed_cast #(
        .LANES(`BN_LANES), .IN_W(`BN_IN_W), .IN_F(`BN_IN_F),
        .OUT_W(`BN_SUB_W), .OUT_F(`BN_SUB_F)
    ) cast_data_to_sub (
        .data_in (data_in),
        .data_out(data_sub)
    );

    fixed_cast #(
        .LANES(`BN_LANES), .IN_W(`BN_IN_W), .IN_F(`BN_IN_F),
        .OUT_W(`BN_SUB_W), .OUT_F(`BN_SUB_F)
    ) cast_mean_to_sub (
        .data_in (mean),
        .data_out(mean_sub)
    );

    fixed_cast #(
        .LANES(`BN_LANES), .IN_W(`BN_IN_W), .IN_F(`BN_IN_F),
        .OUT_W(`BN_ADD_W), .OUT_F(`BN_ADD_F)
    ) cast_bias_to_add (
        .data_in (bias),
        .data_out(bias_add)
    );

    // A stage takes a new beat when it is empty or when its beat leaves in the same cycle
    assign add_accept = (add_state == EMPTY) || skid_ready;
    assign mul_accept = (mul_state == EMPTY) || add_load;
    assign sub_accept = (sub_state == EMPTY) || mul_load;

    // Each join fires only when both of its inputs are valid
    assign sub_load = data_in_valid && mean_valid && sub_accept;
    assign mul_load = (sub_state == FULL) && weight_valid && mul_accept;
    assign add_load = (mul_state == FULL) && bias_valid && add_accept;

    assign data_in_ready = mean_valid && sub_accept;
    assign mean_ready    = data_in_valid && sub_accept;
    assign weight_ready  = (sub_state == FULL) && mul_accept;
    assign bias_ready    = (mul_state == FULL) && add_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            sub_state <= EMPTY;
            mul_state <= EMPTY;
            add_state <= EMPTY;
        end else begin
            if (sub_load) begin
                sub_state <= FULL;
            end else if (mul_load) begin
                sub_state <= EMPTY;
            end

            if (mul_load) begin
                mul_state <= FULL;
            end else if (add_load) begin
                mul_state <= EMPTY;
            end

            if (add_load) begin
                add_state <= FULL;
            end else if (skid_ready) begin
                add_state <= EMPTY;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `BN_LANES; i++) begin
            if (sub_load) begin
                sub_reg.lane[i] <= $signed(data_sub.lane[i]) - $signed(mean_sub.lane[i]);
            end
            if (mul_load) begin
                mul_reg.lane[i] <= $signed(sub_reg.lane[i]) * $signed(weight.lane[i]);
            end
            // The product already has the sum's fraction bits and only needs sign extension
            if (add_load) begin
                add_reg.lane[i] <= $signed(mul_reg.lane[i]) + $signed(bias_add.lane[i]);
            end
        end
    end

    fixed_cast #(
        .LANES(`BN_LANES), .IN_W(`BN_ADD_W), .IN_F(`BN_ADD_F),
        .OUT_W(`BN_OUT_W), .OUT_F(`BN_OUT_F)
    ) cast_sum_to_out (
        .data_in (add_reg),
        .data_out(sum_out)
    );

    skid_buffer #(
        .WIDTH(`BN_LANES * `BN_OUT_W)
    ) u_skid (
        .clk           (clk),
        .rst           (rst),
        .data_in       (sum_out),
        .data_in_valid (add_state == FULL),
        .data_in_ready (skid_ready),
        .data_out      (data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    // Free running clock that starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tb_batch_norm.sv ====
`default_nettype none

`include "batch_norm_defs.svh"

module tb_batch_norm;

    import batch_norm_pkg::*;

    // Bias alignment and output scaling each move the binary point by three bits
    localparam int BIAS_SHIFT = 3;
    localparam int OUT_SHIFT  = 3;
    localparam int OUT_MAX    = 127;
    localparam int OUT_MIN    = -128;
    localparam int TIMEOUT    = 400 * 20 * 8;

    logic      clk;
    logic      rst;
    in_beat_t  beat_r [4];
    logic [3:0] valid_r;
    wire [3:0] ready_w;
    out_beat_t data_out;
    logic      data_out_valid;
    logic      data_out_ready;

    logic [15:0] lfsr;
    logic [3:0]  fired;
    in_beat_t    data_q[$];
    in_beat_t    mean_q[$];
    in_beat_t    weight_q[$];
    in_beat_t    bias_q[$];
    int          accept_q[$];
    int          edge_count;
    int          prev_accept;
    int          in_count;
    int          out_count;
    int          value_errors;
    int          proto_errors;
    bit          check_latency;
    bit          held;
    out_beat_t   held_beat;
    string       test_name;

    tb_clock_gen #(.PERIOD(8)) clock_source (.clk(clk));

    fixed_batch_norm1d DUT (
        .clk           (clk),
        .rst           (rst),
        .data_in       (beat_r[0]),
        .data_in_valid (valid_r[0]),
        .data_in_ready (ready_w[0]),
        .mean          (beat_r[1]),
        .mean_valid    (valid_r[1]),
        .mean_ready    (ready_w[1]),
        .weight        (beat_r[2]),
        .weight_valid  (valid_r[2]),
        .weight_ready  (ready_w[2]),
        .bias          (beat_r[3]),
        .bias_valid    (valid_r[3]),
        .bias_ready    (ready_w[3]),
        .data_out      (data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int in_value(logic [`BN_IN_W-1:0] v);
        return {{(32 - `BN_IN_W){v[`BN_IN_W-1]}}, v};
    endfunction

    function automatic int out_value(logic [`BN_OUT_W-1:0] v);
        return {{(32 - `BN_OUT_W){v[`BN_OUT_W-1]}}, v};
    endfunction

    // Expected result worked out lane by lane in plain integers
    function automatic out_beat_t ref_norm(in_beat_t d, in_beat_t m, in_beat_t w, in_beat_t b);
        out_beat_t r;
        int diff;
        int prod;
        int sum;
        int res;
        for (int i = 0; i < `BN_LANES; i++) begin
            diff = in_value(d.lane[i]) - in_value(m.lane[i]);
            prod = diff * in_value(w.lane[i]);
            sum  = prod + (in_value(b.lane[i]) <<< BIAS_SHIFT);
            res  = sum >>> OUT_SHIFT;
            if (res > OUT_MAX) begin
                res = OUT_MAX;
            end else if (res < OUT_MIN) begin
                res = OUT_MIN;
            end
            r.lane[i] = res[`BN_OUT_W-1:0];
        end
        return r;
    endfunction

    // Extreme beats put data and mean at opposite ends, paired by beat index
    function automatic in_beat_t make_beat(int s, int idx, bit extreme);
        in_beat_t    beat;
        logic [31:0] bits;
        bit          high;
        for (int i = 0; i < `BN_LANES; i++) begin
            high = ((i + idx) % 2) == 0;
            bits = take_bits(`BN_IN_W);
            if (!extreme || s == 3) begin
                beat.lane[i] = bits[`BN_IN_W-1:0];
            end else if (s == 0) begin
                beat.lane[i] = high ? 8'h7F : 8'h80;
            end else if (s == 1) begin
                beat.lane[i] = high ? 8'h80 : 8'h7F;
            end else begin
                beat.lane[i] = bits[0] ? 8'h7F : 8'h81;
            end
        end
        return beat;
    endfunction

    task automatic check_output();
        in_beat_t  d;
        in_beat_t  m;
        in_beat_t  w;
        in_beat_t  b;
        out_beat_t expected;
        int        acc;
        out_count++;
        if (data_q.size() == 0 || mean_q.size() == 0 || weight_q.size() == 0 ||
            bias_q.size() == 0) begin
            proto_errors++;
            $display("%s: an output beat arrived with no matching input beats", test_name);
            return;
        end
        d = data_q.pop_front();
        m = mean_q.pop_front();
        w = weight_q.pop_front();
        b = bias_q.pop_front();
        acc = accept_q.pop_front();
        expected = ref_norm(d, m, w, b);
        for (int i = 0; i < `BN_LANES; i++) begin
            if (out_value(expected.lane[i]) != out_value(data_out.lane[i])) begin
                value_errors++;
                $display("Error: %s beat %0d lane %0d expected %0d actual %0d", test_name,
                         out_count, i, out_value(expected.lane[i]),
                         out_value(data_out.lane[i]));
            end
        end
        // Valid rises after edge k+3, so with ready high the transfer is on edge k+4
        if (check_latency && (edge_count - acc) != 4) begin
            proto_errors++;
            $display("%s: beat %0d left %0d edges after it was accepted instead of 4",
                     test_name, out_count, edge_count - acc);
        end
    endtask

    // Records every handshake and compares each output transfer
    always @(posedge clk) begin
        if (!rst) begin
            edge_count++;
            fired = valid_r & ready_w;
            if (fired[0]) begin
                // With every stream busy the data beats are taken on back-to-back edges
                if (check_latency && prev_accept != 0 && edge_count != prev_accept + 1) begin
                    proto_errors++;
                    $display("%s: data beat taken %0d edges after the previous one instead of 1",
                             test_name, edge_count - prev_accept);
                end
                prev_accept = edge_count;
                data_q.push_back(beat_r[0]);
                accept_q.push_back(edge_count);
                in_count++;
            end
            if (fired[1]) mean_q.push_back(beat_r[1]);
            if (fired[2]) weight_q.push_back(beat_r[2]);
            if (fired[3]) bias_q.push_back(beat_r[3]);
            if (held && (!data_out_valid || data_out != held_beat)) begin
                proto_errors++;
                $display("%s: data_out changed while it was stalled", test_name);
            end
            held      = data_out_valid && !data_out_ready;
            held_beat = data_out;
            if (data_out_valid && data_out_ready) begin
                check_output();
            end
        end
    end

    task automatic run_streams(int n, bit extreme, bit gaps, bit random_ready);
        int          sent [4];
        logic [31:0] bits;
        bit          busy;
        sent = '{default: 0};
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int s = 0; s < 4; s++) begin
                if (fired[s]) begin
                    sent[s]++;
                    valid_r[s] = 1'b0;
                end
                bits = gaps ? take_bits(1) : '0;
                if (!valid_r[s] && sent[s] < n && bits[0] == 1'b0) begin
                    beat_r[s]  = make_beat(s, sent[s], extreme);
                    valid_r[s] = 1'b1;
                end
                if (sent[s] < n) busy = 1'b1;
            end
            bits = random_ready ? take_bits(1) : 32'd1;
            data_out_ready = bits[0];
        end
        data_out_ready = 1'b1;
        while (out_count < in_count) @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("test failed");
        $finish;
    end

    initial begin
        lfsr           = 16'd36855;
        rst            = 1'b1;
        valid_r        = '0;
        beat_r         = '{default: '0};
        data_out_ready = 1'b0;
        test_name      = "reset";
        repeat (5) begin
            @(negedge clk);
            if (data_out_valid) begin
                proto_errors++;
                $display("%s: data_out_valid was high during reset", test_name);
            end
        end
        rst = 1'b0;

        // Data waits with mean idle, so the join must hold its ready low
        test_name  = "idle_mean";
        beat_r[0]  = make_beat(0, 0, 1'b0);
        valid_r[0] = 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (ready_w[0] || data_out_valid) begin
                proto_errors++;
                $display("%s: data_in_ready or data_out_valid rose with mean idle", test_name);
            end
        end

        test_name     = "stream";
        prev_accept   = 0;
        check_latency = 1'b1;
        run_streams(64, 1'b0, 1'b0, 1'b0);
        check_latency = 1'b0;

        test_name = "saturate";
        run_streams(32, 1'b1, 1'b0, 1'b0);

        test_name = "valid_gaps";
        run_streams(100, 1'b0, 1'b1, 1'b0);

        test_name = "backpressure";
        run_streams(100, 1'b0, 1'b0, 1'b1);

        if (data_q.size() != 0 || mean_q.size() != 0 || weight_q.size() != 0 ||
            bias_q.size() != 0 || in_count != out_count) begin
            proto_errors++;
            $display("Accepted beats were left without a result (%0d in, %0d out)",
                     in_count, out_count);
        end
        $display("Checks done with %0d value errors and %0d protocol errors",
                 value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== batch_norm.f ====
+incdir+.
batch_norm_pkg.sv
fixed_cast.sv
skid_buffer.sv
fixed_batch_norm1d.sv
tb_clock_gen.sv
tb_batch_norm.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_batch_norm \
    -f batch_norm.f --Mdir obj_dir -o tb_batch_norm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_batch_norm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi

if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
